// ==== common/sample_buffer_pkg.sv ====
// sizes assume channels is a power of two and equals the bank count; one clock domain only
package sample_buffer_pkg;

  // input channels, also the number of banks
  localparam int channels = 4;

  // words per bank
  localparam int buffer_depth = 64;

  // bits per sample
  localparam int data_width = 16;

  // depth count must reach buffer_depth itself
  localparam int depth_width = $clog2(buffer_depth + 1);

  localparam int addr_width = $clog2(buffer_depth);
  localparam int bank_sel_width = $clog2(channels);

  // number of active channels is 1 << mode
  typedef enum logic [1:0] {
    one_channel  = 2'd0,
    two_channel  = 2'd1,
    four_channel = 2'd2
  } bank_mode_e;

  typedef enum logic {
    cap_idle   = 1'b0,
    cap_active = 1'b1
  } capture_state_e;

  typedef enum logic [1:0] {
    rd_idle  = 2'd0,
    rd_fetch = 2'd1,
    rd_drain = 2'd2
  } readout_state_e;

endpackage

// ==== sample_buffer/bank_memory.sv ====
// one bank, write-once until clear; read data arrives one cycle after read_enable
`timescale 1ns/1ps

module bank_memory (
  input  logic                                    capture_clk,
  input  logic                                    readout_reset,
  input  logic                                    clear,
  input  logic                                    write_enable,
  input  logic [sample_buffer_pkg::data_width-1:0]  write_data,
  output logic                                    full,
  output logic [sample_buffer_pkg::depth_width-1:0] depth,
  input  logic                                    read_enable,
  input  logic [sample_buffer_pkg::addr_width-1:0]  read_addr,
  output logic [sample_buffer_pkg::data_width-1:0]  read_data
);
  import sample_buffer_pkg::*;

  logic [data_width-1:0] mem [buffer_depth];
  logic [addr_width-1:0] wr_ptr;
  logic                  do_write;

  assign full = (depth == depth_width'(buffer_depth));

  // clear wins over a write in the same cycle
  assign do_write = write_enable && !full && !clear;

  always_ff @(posedge capture_clk) begin
    if (readout_reset) begin
      wr_ptr <= '0;
      depth  <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      depth  <= '0;
    end else if (do_write) begin
      wr_ptr <= wr_ptr + 1'b1;
      // stops at buffer_depth since full blocks further writes
      depth  <= depth + 1'b1;
    end
  end

  // sample storage
  always_ff @(posedge capture_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= write_data;
    end
  end

  // registered read port
  always_ff @(posedge capture_clk) begin
    if (read_enable) begin
      read_data <= mem[read_addr];
    end
  end

endmodule

// ==== sample_buffer/bank_router.sv ====
// mode is sampled on capture_start; an undefined mode value acts as four_channel
`timescale 1ns/1ps

module bank_router (
  input  logic                                   capture_clk,
  input  logic                                   readout_reset,
  input  logic [sample_buffer_pkg::channels-1:0] capture_valid,
  input  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0]
                                                 capture_data,
  input  sample_buffer_pkg::bank_mode_e          capture_banking_mode,
  input  logic                                   capture_start,
  input  logic                                   capture_stop,
  input  logic [sample_buffer_pkg::channels-1:0] bank_full,
  output logic [sample_buffer_pkg::channels-1:0] bank_write_enable,
  output logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0]
                                                 bank_write_data,
  output logic                                   bank_clear,
  output logic                                   capture_full
);
  import sample_buffer_pkg::*;

  capture_state_e            state;
  bank_mode_e                mode_q;
  logic [bank_sel_width:0]   active_cnt;
  logic [bank_sel_width-1:0] cur_bank [channels];
  logic [bank_sel_width-1:0] next_bank [channels];
  logic [channels-1:0]       chain_end;
  logic                      write_allowed;

  always_comb begin
    case (mode_q)
      one_channel:  active_cnt = (bank_sel_width + 1)'(1);
      two_channel:  active_cnt = (bank_sel_width + 1)'(2);
      four_channel: active_cnt = (bank_sel_width + 1)'(channels);
      default:      active_cnt = (bank_sel_width + 1)'(channels);
    endcase
  end

  // last bank of each chain, then hop along the chain once a bank fills
  always_comb begin
    for (int b = 0; b < channels; b++) begin
      chain_end[b] = (b + int'(active_cnt)) >= channels;
    end
    for (int ch = 0; ch < channels; ch++) begin
      next_bank[ch] = cur_bank[ch];
      if (bank_full[cur_bank[ch]] && !chain_end[cur_bank[ch]]) begin
        next_bank[ch] = cur_bank[ch] + bank_sel_width'(active_cnt);
      end
    end
  end

  // any active chain exhausted
  assign capture_full  = |(bank_full & chain_end);
  assign write_allowed = (state == cap_active) && !capture_full;
  assign bank_clear    = capture_start;

  always_comb begin
    logic [bank_sel_width-1:0] owner;
    for (int b = 0; b < channels; b++) begin
      // b mod k
      owner = bank_sel_width'(b) & bank_sel_width'(active_cnt - 1'b1);
      bank_write_data[b]   = capture_data[owner];
      bank_write_enable[b] = write_allowed && capture_valid[owner] &&
                             (next_bank[owner] == bank_sel_width'(b));
    end
  end

  always_ff @(posedge capture_clk) begin
    if (readout_reset) begin
      state  <= cap_idle;
      mode_q <= one_channel;
      for (int ch = 0; ch < channels; ch++) begin
        cur_bank[ch] <= bank_sel_width'(ch);
      end
    end else if (capture_start) begin
      state  <= cap_active;
      mode_q <= capture_banking_mode;
      // each chain begins at its own channel index
      for (int ch = 0; ch < channels; ch++) begin
        cur_bank[ch] <= bank_sel_width'(ch);
      end
    end else if (state == cap_active) begin
      for (int ch = 0; ch < channels; ch++) begin
        cur_bank[ch] <= next_bank[ch];
      end
      if (capture_stop || capture_full) begin
        state <= cap_idle;
      end
    end
  end

endmodule

// ==== sample_buffer/readout_sequencer.sv ====
// always streams all banks in full; readout_start must drop and rise again to restart
`timescale 1ns/1ps

module readout_sequencer (
  input  logic                                       capture_clk,
  input  logic                                       readout_reset,
  input  logic                                       readout_start,
  output logic [sample_buffer_pkg::channels-1:0]       bank_read_enable,
  output logic [sample_buffer_pkg::addr_width-1:0]     read_addr,
  output logic [sample_buffer_pkg::bank_sel_width-1:0] read_bank,
  input  logic [sample_buffer_pkg::data_width-1:0]     bank_read_data,
  output logic                                       readout_valid,
  input  logic                                       readout_ready,
  output logic [sample_buffer_pkg::data_width-1:0]     readout_data,
  output logic                                       readout_last
);
  import sample_buffer_pkg::*;

  readout_state_e                          state;
  logic                                    armed;
  logic                                    go;
  logic [bank_sel_width+addr_width-1:0]    word_cnt;
  logic                                    has_space;
  logic                                    issue;
  logic                                    issue_last;
  logic                                    pending;
  logic                                    pending_last;
  logic [data_width-1:0]                   buf_data [2];
  logic [1:0]                              buf_last;
  logic                                    wr_sel;
  logic                                    rd_sel;
  logic [1:0]                              count;
  logic                                    pop;

  assign go = (state == rd_idle) && readout_start && armed;

  // buffer entries plus the read in flight, less the word leaving now
  assign has_space = (3'(count) + 3'(pending)) < (3'd2 + 3'(pop));

  // first read goes out in the start cycle itself
  assign issue      = ((state == rd_fetch) || go) && has_space;
  assign issue_last = issue && (word_cnt == '1);

  assign read_addr        = word_cnt[addr_width-1:0];
  assign bank_read_enable = issue ?
                            (channels'(1) << word_cnt[bank_sel_width+addr_width-1:addr_width]) :
                            '0;

  assign readout_valid = (count != 2'd0);
  assign readout_data  = buf_data[rd_sel];
  assign readout_last  = readout_valid && buf_last[rd_sel];
  assign pop           = readout_valid && readout_ready;

  always_ff @(posedge capture_clk) begin
    if (readout_reset) begin
      state    <= rd_idle;
      armed    <= 1'b0;
      word_cnt <= '0;
      pending  <= 1'b0;
      wr_sel   <= 1'b0;
      rd_sel   <= 1'b0;
      count    <= 2'd0;
    end else begin
      if (!readout_start) begin
        armed <= 1'b1;
      end else if (go) begin
        armed <= 1'b0;
      end

      case (state)
        rd_idle: begin
          if (go) begin
            state <= rd_fetch;
          end
        end
        rd_fetch: begin
          if (issue_last) begin
            state <= rd_drain;
          end
        end
        rd_drain: begin
          if (pop && readout_last) begin
            state <= rd_idle;
          end
        end
        default: state <= rd_idle;
      endcase

      // wraps back to zero after the final word
      if (issue) begin
        word_cnt <= word_cnt + 1'b1;
      end
      pending <= issue;
      if (pending) begin
        wr_sel <= ~wr_sel;
      end
      if (pop) begin
        rd_sel <= ~rd_sel;
      end
      count <= count + 2'(pending) - 2'(pop);
    end
  end

  // payload path
  always_ff @(posedge capture_clk) begin
    if (issue) begin
      read_bank <= word_cnt[bank_sel_width+addr_width-1:addr_width];
    end
    pending_last <= issue_last;
    if (pending) begin
      buf_data[wr_sel] <= bank_read_data;
      buf_last[wr_sel] <= pending_last;
    end
  end

endmodule

// ==== hw/sample_buffer_top.sv ====
// single clock; readout_start is a level held until the stream ends
`timescale 1ns/1ps

module sample_buffer_top (
  input  logic                                   capture_clk,
  input  logic                                   readout_reset,
  input  logic [sample_buffer_pkg::channels-1:0] capture_valid,
  input  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0]
                                                 capture_data,
  input  sample_buffer_pkg::bank_mode_e          capture_banking_mode,
  input  logic                                   capture_start,
  input  logic                                   capture_stop,
  output logic                                   capture_full,
  output logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::depth_width-1:0]
                                                 capture_write_depth,
  input  logic                                   readout_start,
  output logic                                   readout_valid,
  input  logic                                   readout_ready,
  output logic [sample_buffer_pkg::data_width-1:0] readout_data,
  output logic                                   readout_last
);
  import sample_buffer_pkg::*;

  logic [channels-1:0]                 bank_full;
  logic [channels-1:0]                 bank_write_enable;
  logic [channels-1:0][data_width-1:0] bank_write_data;
  logic                                bank_clear;
  logic [channels-1:0]                 bank_read_enable;
  logic [addr_width-1:0]               read_addr;
  logic [bank_sel_width-1:0]           read_bank;
  logic [data_width-1:0]               bank_read_data_all [channels];
  logic [data_width-1:0]               bank_read_data;

  bank_router router0 (
    .capture_clk          (capture_clk),
    .readout_reset        (readout_reset),
    .capture_valid        (capture_valid),
    .capture_data         (capture_data),
    .capture_banking_mode (capture_banking_mode),
    .capture_start        (capture_start),
    .capture_stop         (capture_stop),
    .bank_full            (bank_full),
    .bank_write_enable    (bank_write_enable),
    .bank_write_data      (bank_write_data),
    .bank_clear           (bank_clear),
    .capture_full         (capture_full)
  );

  for (genvar b = 0; b < channels; b++) begin : bank_gen
    bank_memory mem0 (
      .capture_clk   (capture_clk),
      .readout_reset (readout_reset),
      .clear         (bank_clear),
      .write_enable  (bank_write_enable[b]),
      .write_data    (bank_write_data[b]),
      .full          (bank_full[b]),
      .depth         (capture_write_depth[b]),
      .read_enable   (bank_read_enable[b]),
      .read_addr     (read_addr),
      .read_data     (bank_read_data_all[b])
    );
  end

  // bank of the read issued last cycle
  assign bank_read_data = bank_read_data_all[read_bank];

  readout_sequencer sequencer0 (
    .capture_clk      (capture_clk),
    .readout_reset    (readout_reset),
    .readout_start    (readout_start),
    .bank_read_enable (bank_read_enable),
    .read_addr        (read_addr),
    .read_bank        (read_bank),
    .bank_read_data   (bank_read_data),
    .readout_valid    (readout_valid),
    .readout_ready    (readout_ready),
    .readout_data     (readout_data),
    .readout_last     (readout_last)
  );

endmodule

// ==== tb/sample_buffer_props.sv ====
// bound into sample_buffer_top; all checks are idle while readout_reset is high
`timescale 1ns/1ps

module sample_buffer_props (
  input logic                                   capture_clk,
  input logic                                   readout_reset,
  input logic                                   readout_valid,
  input logic                                   readout_ready,
  input logic [sample_buffer_pkg::data_width-1:0] readout_data,
  input logic                                   readout_last,
  input logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::depth_width-1:0]
                                                capture_write_depth,
  input logic [sample_buffer_pkg::channels-1:0] bank_write_enable,
  input logic [sample_buffer_pkg::channels-1:0] bank_full
);
  import sample_buffer_pkg::*;

  // stalled word holds until taken
  stream_hold: assert property (@(posedge capture_clk) disable iff (readout_reset)
    readout_valid && !readout_ready |=>
      readout_valid && $stable(readout_data) && $stable(readout_last))
    else $error("stream changed while stalled");

  for (genvar b = 0; b < channels; b++) begin : bank_chk
    depth_limit: assert property (@(posedge capture_clk) disable iff (readout_reset)
      capture_write_depth[b] <= depth_width'(buffer_depth))
      else $error("bank %0d depth above limit", b);

    write_not_full: assert property (@(posedge capture_clk) disable iff (readout_reset)
      bank_write_enable[b] |-> !bank_full[b])
      else $error("write enable on full bank %0d", b);
  end

endmodule

bind sample_buffer_top sample_buffer_props props0 (
  .capture_clk         (capture_clk),
  .readout_reset       (readout_reset),
  .readout_valid       (readout_valid),
  .readout_ready       (readout_ready),
  .readout_data        (readout_data),
  .readout_last        (readout_last),
  .capture_write_depth (capture_write_depth),
  .bank_write_enable   (bank_write_enable),
  .bank_full           (bank_full)
);

// ==== tb/sample_buffer_tb.sv ====
// checks only the words written in the latest capture; older bank contents are not modelled
`timescale 1ns/1ps

module sample_buffer_tb;
  import sample_buffer_pkg::*;

  // 7 captures and 3 readouts need about 2500 cycles plus margin
  localparam int timeout_cycles = 20000;
  localparam int total_words = channels * buffer_depth;

  logic                                capture_clk;
  logic                                readout_reset;
  logic [channels-1:0]                 capture_valid;
  logic [channels-1:0][data_width-1:0] capture_data;
  bank_mode_e                          capture_banking_mode;
  logic                                capture_start;
  logic                                capture_stop;
  logic                                capture_full;
  logic [channels-1:0][depth_width-1:0] capture_write_depth;
  logic                                readout_start;
  logic                                readout_valid;
  logic                                readout_ready;
  logic [data_width-1:0]               readout_data;
  logic                                readout_last;

  // samples accepted per channel, in order
  logic [data_width-1:0] sent_q [channels][$];
  int active_k = 1;
  bit model_active = 1'b0;
  int errors = 0;
  int tests_run = 0;
  int test_err_base = 0;
  int cycle_count = 0;

  sample_buffer_top dut0 (
    .capture_clk          (capture_clk),
    .readout_reset        (readout_reset),
    .capture_valid        (capture_valid),
    .capture_data         (capture_data),
    .capture_banking_mode (capture_banking_mode),
    .capture_start        (capture_start),
    .capture_stop         (capture_stop),
    .capture_full         (capture_full),
    .capture_write_depth  (capture_write_depth),
    .readout_start        (readout_start),
    .readout_valid        (readout_valid),
    .readout_ready        (readout_ready),
    .readout_data         (readout_data),
    .readout_last         (readout_last)
  );

  initial begin
    capture_clk = 1'b0;
    forever #5 capture_clk = ~capture_clk;
  end

  always @(posedge capture_clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic int mode_channels(input bank_mode_e mode);
    case (mode)
      one_channel: return 1;
      two_channel: return 2;
      default:     return channels;
    endcase
  endfunction

  // any active chain holds all of its banks' worth of samples
  function automatic bit model_full();
    for (int c = 0; c < active_k; c++) begin
      if (sent_q[c].size() >= (channels / active_k) * buffer_depth) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // bank b is position b div k in the chain of channel b mod k
  function automatic int expected_depth(input int b);
    int n;
    n = sent_q[b % active_k].size() - (b / active_k) * buffer_depth;
    if (n < 0) begin
      return 0;
    end
    return (n > buffer_depth) ? buffer_depth : n;
  endfunction

  task automatic check_depth(input string name, input logic [depth_width-1:0] exp,
                             input logic [depth_width-1:0] act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_word(input int bank, input int word, input logic [data_width-1:0] exp,
                            input logic [data_width-1:0] act);
    if (act !== exp) begin
      $display("Mismatch at %0t: readout_data bank %0d word %0d expected %h, got %h",
               $time, bank, word, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_all_depths();
    for (int b = 0; b < channels; b++) begin
      check_depth($sformatf("capture_write_depth[%0d]", b),
                  depth_width'(expected_depth(b)), capture_write_depth[b]);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  task automatic idle_cycle();
    @(posedge capture_clk);
    #1;
    capture_valid = '0;
    capture_start = 1'b0;
    capture_stop  = 1'b0;
  endtask

  task automatic start_capture(input bank_mode_e mode);
    @(posedge capture_clk);
    #1;
    capture_valid        = '0;
    capture_banking_mode = mode;
    capture_start        = 1'b1;
    active_k = mode_channels(mode);
    for (int c = 0; c < channels; c++) begin
      sent_q[c].delete();
    end
    model_active = 1'b1;
  endtask

  // channel 0 uses lead_pct, the other channels other_pct
  task automatic drive_capture_cycle(input int lead_pct, input int other_pct);
    logic [channels-1:0]   v;
    logic [data_width-1:0] d;
    bit                    accept;
    int                    pct;
    @(posedge capture_clk);
    #1;
    accept = model_active && !model_full();
    capture_start = 1'b0;
    capture_stop  = 1'b0;
    for (int c = 0; c < channels; c++) begin
      pct = (c == 0) ? lead_pct : other_pct;
      d = data_width'($urandom);
      v[c] = int'($urandom % 100) < pct;
      capture_data[c] = d;
      if (accept && v[c] && c < active_k) begin
        sent_q[c].push_back(d);
      end
    end
    capture_valid = v;
  endtask

  task automatic stop_capture();
    @(posedge capture_clk);
    #1;
    capture_valid = '0;
    capture_stop  = 1'b1;
    @(posedge capture_clk);
    #1;
    capture_stop = 1'b0;
    model_active = 1'b0;
  endtask

  task automatic run_short_capture(input bank_mode_e mode);
    int cycles;
    int sum;
    cycles = 5 + int'($urandom % 16);
    start_capture(mode);
    repeat (cycles) drive_capture_cycle(60, 60);
    stop_capture();
    @(negedge capture_clk);
    check_all_depths();
    for (int c = 0; c < active_k; c++) begin
      sum = 0;
      for (int b = c; b < channels; b += active_k) begin
        sum += int'(capture_write_depth[b]);
      end
      check_depth($sformatf("chain %0d depth sum", c),
                  depth_width'(sent_q[c].size()), depth_width'(sum));
    end
    check_flag("capture_full", 1'b0, capture_full);
    finish_test($sformatf("short capture %s", mode.name()));
  endtask

  task automatic run_full_capture(input bank_mode_e mode);
    start_capture(mode);
    // channel 0 fills first so the other chains still have room
    while (!model_full()) begin
      drive_capture_cycle(100, 75);
    end
    // late samples must be dropped
    repeat (5) drive_capture_cycle(100, 100);
    idle_cycle();
    model_active = 1'b0;
    @(negedge capture_clk);
    check_flag("capture_full", 1'b1, capture_full);
    check_all_depths();
    finish_test($sformatf("full capture %s", mode.name()));
  endtask

  task automatic run_readout(input int ready_pct, input string name);
    int words;
    int bank;
    int word;
    int idx;
    words = 0;
    @(posedge capture_clk);
    #1;
    readout_start = 1'b1;
    readout_ready = int'($urandom % 100) < ready_pct;
    while (words < total_words) begin
      @(negedge capture_clk);
      if (readout_valid && readout_ready) begin
        bank = words / buffer_depth;
        word = words % buffer_depth;
        idx  = (bank / active_k) * buffer_depth + word;
        if (idx < sent_q[bank % active_k].size()) begin
          check_word(bank, word, sent_q[bank % active_k][idx], readout_data);
        end
        check_flag("readout_last", words == total_words - 1, readout_last);
        words++;
      end
      @(posedge capture_clk);
      #1;
      readout_ready = int'($urandom % 100) < ready_pct;
    end
    readout_start = 1'b0;
    repeat (4) begin
      @(negedge capture_clk);
      check_flag("readout_valid", 1'b0, readout_valid);
    end
    finish_test(name);
  endtask

  task automatic run_restart();
    start_capture(one_channel);
    idle_cycle();
    @(negedge capture_clk);
    check_all_depths();
    repeat (150) drive_capture_cycle(70, 70);
    stop_capture();
    @(negedge capture_clk);
    check_all_depths();
    finish_test("restart one_channel");
    run_readout(40, "readout after restart");
  endtask

  initial begin
    void'($urandom(32'h7b5b));
    readout_reset        = 1'b1;
    capture_valid        = '0;
    capture_data         = '0;
    capture_banking_mode = one_channel;
    capture_start        = 1'b0;
    capture_stop         = 1'b0;
    readout_start        = 1'b0;
    readout_ready        = 1'b0;
    repeat (8) @(posedge capture_clk);
    #1;
    readout_reset = 1'b0;
    @(negedge capture_clk);
    check_all_depths();
    check_flag("capture_full", 1'b0, capture_full);
    check_flag("readout_valid", 1'b0, readout_valid);
    check_flag("readout_last", 1'b0, readout_last);
    finish_test("reset");

    run_short_capture(one_channel);
    run_short_capture(two_channel);
    run_short_capture(four_channel);
    run_full_capture(one_channel);
    run_full_capture(two_channel);
    run_full_capture(four_channel);
    run_readout(100, "readout ready high");
    run_readout(50, "readout random ready");
    run_restart();

    @(posedge capture_clk);
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
common/sample_buffer_pkg.sv
sample_buffer/bank_memory.sv
sample_buffer/bank_router.sv
sample_buffer/readout_sequencer.sv
hw/sample_buffer_top.sv
tb/sample_buffer_props.sv
tb/sample_buffer_tb.sv

// ==== Makefile ====
# Verilator build and run for the sample buffer testbench

VERILATOR ?= verilator
TOP       ?= sample_buffer_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
